// ==== list.f ====
+incdir+rtl
rtl/inv_pkg.sv
rtl/inv_sched.sv
rtl/array_div.sv
rtl/array_mult.sv
rtl/cholesky.sv
rtl/lt_inverse.sv
rtl/gram_mult.sv
rtl/inverse.sv
tb/tb_clock.sv
tb/tb_inverse.sv

// ==== rtl/array_div.sv ====
// ############################
// shared pipelined divider lanes, common divisor, INV_DIV_LAT cycles
// ############################
`timescale 1ns/1ns
`include "inv_consts.svh"

module array_div (
	input  logic              i,
	input  logic              rst_n,
	input  inv_pkg::div_req_t req,
	output inv_pkg::lanes_t   quotients
);
	import inv_pkg::*;

	localparam int W = `INV_W;
	localparam int N = `INV_N;
	localparam int LAT = `INV_DIV_LAT;

	// per stage and lane: partial remainder, unused dividend bits, quotient bits
	logic [W:0]   rem_q [LAT][N];
	logic [W-1:0] low_q [LAT][N];
	logic [W-1:0] quo_q [LAT][N];
	logic         neg_q [LAT][N];
	logic [W-1:0] dvs_q [LAT];

	logic [W-1:0]      dvs_mag;
	logic [W+`INV_FRAC-1:0] num [N];
	logic              in_neg [N];

	always_comb begin
		dvs_mag = req.divisor[W-1] ? W'(-req.divisor) : W'(req.divisor);
		for (int l = 0; l < N; l++) begin
			in_neg[l] = req.dividends[l][W-1] ^ req.divisor[W-1];
			// dividend magnitude pre-shifted by the fraction bits
			num[l] = {(req.dividends[l][W-1] ? W'(-req.dividends[l]) :
				W'(req.dividends[l])), `INV_FRAC'(0)};
		end
	end

	always_ff @(posedge i or negedge rst_n) begin
		logic [W:0]   r;
		logic [W-1:0] lo;
		logic [W-1:0] q;
		logic [W-1:0] d;
		if (!rst_n) begin
			for (int s = 0; s < LAT; s++) begin
				dvs_q[s] <= '0;
				for (int l = 0; l < N; l++) begin
					rem_q[s][l] <= '0;
					low_q[s][l] <= '0;
					quo_q[s][l] <= '0;
					neg_q[s][l] <= 1'b0;
				end
			end
		end else begin
			for (int s = 0; s < LAT; s++) begin
				d = (s == 0) ? dvs_mag : dvs_q[s-1];
				dvs_q[s] <= d;
				for (int l = 0; l < N; l++) begin
					if (s == 0) begin
						r = (W+1)'(num[l][W+`INV_FRAC-1:W]);
						lo = num[l][W-1:0];
						q = '0;
						neg_q[s][l] <= in_neg[l];
					end else begin
						r = rem_q[s-1][l];
						lo = low_q[s-1][l];
						q = quo_q[s-1][l];
						neg_q[s][l] <= neg_q[s-1][l];
					end
					// one restoring step
					r = {r[W-1:0], lo[W-1]};
					lo = lo << 1;
					if (r >= {1'b0, d}) begin
						r = r - {1'b0, d};
						q = {q[W-2:0], 1'b1};
					end else begin
						q = {q[W-2:0], 1'b0};
					end
					rem_q[s][l] <= r;
					low_q[s][l] <= lo;
					quo_q[s][l] <= q;
				end
			end
		end
	end

	always_comb begin
		for (int l = 0; l < N; l++)
			quotients[l] = neg_q[LAT-1][l] ? -elem_t'(quo_q[LAT-1][l]) : elem_t'(quo_q[LAT-1][l]);
	end

endmodule

// ==== rtl/array_mult.sv ====
// ############################
// shared registered fixed-point multiplier lanes
// ############################
`timescale 1ns/1ns
`include "inv_consts.svh"

module array_mult (
	input  logic               i,
	input  logic               rst_n,
	input  inv_pkg::mult_req_t req,
	output inv_pkg::lanes_t    products
);
	import inv_pkg::*;

	localparam int W = `INV_W;

	always_ff @(posedge i or negedge rst_n) begin
		elem_t a;
		elem_t b;
		logic signed [2*W-1:0] p;
		if (!rst_n) begin
			products <= '0;
		end else begin
			for (int l = 0; l < `INV_N; l++) begin
				a = req.dataa[l];
				b = req.datab[l];
				p = a * b;
				// round to nearest, back to INV_FRAC fraction bits
				p = p + (2*W)'(1 << (`INV_FRAC - 1));
				products[l] <= elem_t'(p >>> `INV_FRAC);
			end
		end
	end

endmodule

// ==== rtl/cholesky.sv ====
// ############################
// Cholesky factor L, column by column, on the shared arrays
// also owns the shared divisor during the L^-1 row windows
// ############################
`timescale 1ns/1ns
`include "inv_consts.svh"

module cholesky (
	input  logic               i,
	input  logic               rst_n,
	input  logic               run,
	input  inv_pkg::step_t     step,
	input  inv_pkg::mat_t      matrix,
	input  inv_pkg::lanes_t    quotients,
	input  inv_pkg::lanes_t    products,
	output inv_pkg::div_req_t  div_req,
	output inv_pkg::mult_req_t mult_req,
	output inv_pkg::mat_t      lt
);
	import inv_pkg::*;

	localparam int N = `INV_N;
	localparam int RW = 4 * (`INV_W / 2);

	logic        act;
	logic [1:0]  col;
	step_t       offs;
	elem_t       red [N];
	logic [RW+3:0]  sq_rem;
	logic [RW/2-1:0] sq_root;
	logic [RW-1:0]   sq_rad;

	// which column window is running, and where in it
	always_comb begin
		act = 1'b0;
		col = '0;
		offs = '0;
		for (int j = 0; j < N; j++) begin
			if (run && step >= step_t'(`INV_STEP_CHOL + j * `INV_CHOL_LEN) &&
				step < step_t'(`INV_STEP_CHOL + (j + 1) * `INV_CHOL_LEN)) begin
				act = 1'b1;
				col = 2'(j);
				offs = step - step_t'(`INV_STEP_CHOL + j * `INV_CHOL_LEN);
			end
		end
	end

	always_comb begin
		mult_req = '0;
		div_req = '0;
		if (act) begin
			// row r dot product over earlier columns
			for (int r = 0; r < N; r++) begin
				if (offs == step_t'(r) && r >= col) begin
					for (int k = 0; k < N; k++) begin
						if (k < col) begin
							mult_req.dataa[k] = lt[r][k];
							mult_req.datab[k] = lt[col][k];
						end
					end
				end
			end
			if (offs == step_t'(`INV_CHOL_DIV)) begin
				div_req.divisor = elem_t'(sq_root);
				for (int r = 0; r < N; r++)
					if (r > col)
						div_req.dividends[r] = red[r];
			end
		end
		// diagonal of L for the triangular inverse divides
		for (int r = 0; r < N; r++) begin
			if (run && step == step_t'(`INV_STEP_LTI + r * `INV_LTI_LEN + `INV_LTI_DIV))
				div_req.divisor = lt[r][r];
		end
	end

	always_ff @(posedge i or negedge rst_n) begin
		logic [RW+3:0] sr;
		logic [RW/2-1:0] rt;
		logic [RW-1:0] rd;
		logic [RW+3:0] trial;
		if (!rst_n) begin
			lt <= '0;
			for (int r = 0; r < N; r++)
				red[r] <= '0;
			sq_rem <= '0;
			sq_root <= '0;
			sq_rad <= '0;
		end else if (act) begin
			// reduced entries, one product cycle after each request
			for (int r = 0; r < N; r++)
				if (offs == step_t'(r + 1) && r >= col)
					red[r] <= matrix[r][col] - products[0] - products[1] - products[2];
			if (offs == step_t'(`INV_CHOL_SQRT)) begin
				sq_rad <= RW'({red[col], `INV_FRAC'(0)});
				sq_rem <= '0;
				sq_root <= '0;
			end else if (offs > step_t'(`INV_CHOL_SQRT) &&
				offs < step_t'(`INV_CHOL_DIV)) begin
				sr = sq_rem;
				rt = sq_root;
				rd = sq_rad;
				// two root bits per cycle
				for (int b = 0; b < 2; b++) begin
					sr = {sr[RW+1:0], rd[RW-1:RW-2]};
					rd = rd << 2;
					trial = {2'b00, rt, 2'b01};
					if (sr >= trial) begin
						sr = sr - trial;
						rt = {rt[RW/2-2:0], 1'b1};
					end else begin
						rt = {rt[RW/2-2:0], 1'b0};
					end
				end
				sq_rem <= sr;
				sq_root <= rt;
				sq_rad <= rd;
			end
			if (offs == step_t'(`INV_CHOL_DIV))
				lt[col][col] <= elem_t'(sq_root);
			if (offs == step_t'(`INV_CHOL_DIV + `INV_DIV_LAT)) begin
				for (int r = 0; r < N; r++)
					if (r > col)
						lt[r][col] <= quotients[r];
			end
		end
	end

endmodule

// ==== rtl/gram_mult.sv ====
// ############################
// final product L^-T * L^-1, one row per step, latched at the last step
// ############################
`timescale 1ns/1ns
`include "inv_consts.svh"

module gram_mult (
	input  logic           i,
	input  logic           rst_n,
	input  inv_pkg::step_t step,
	input  inv_pkg::mat_t  lt_inverse,
	output inv_pkg::mat_t  inv
);
	import inv_pkg::*;

	localparam int N = `INV_N;
	localparam int W = `INV_W;

	mat_t xt;
	mat_t x;
	mat_t acc;

	always_ff @(posedge i or negedge rst_n) begin
		logic signed [2*W+1:0] s;
		elem_t a;
		elem_t b;
		if (!rst_n) begin
			xt <= '0;
			x <= '0;
			acc <= '0;
			inv <= '0;
		end else begin
			if (step == step_t'(`INV_STEP_GRAM)) begin
				for (int r = 0; r < N; r++)
					for (int c = 0; c < N; c++)
						xt[r][c] <= lt_inverse[c][r];
				x <= lt_inverse;
			end
			for (int r = 0; r < N; r++) begin
				if (step == step_t'(`INV_STEP_GRAM + 1 + r)) begin
					// one multiply-accumulate lane per column
					for (int c = 0; c < N; c++) begin
						s = '0;
						for (int k = 0; k < N; k++) begin
							a = xt[r][k];
							b = x[k][c];
							s = s + a * b;
						end
						s = s + (2*W+2)'(1 << (`INV_FRAC - 1));
						acc[r][c] <= elem_t'(s >>> `INV_FRAC);
					end
				end
			end
			if (step == step_t'(`INV_STEP_LAST))
				inv <= acc;
		end
	end

endmodule

// ==== rtl/inv_consts.svh ====
// ############################
// sizes, number format and the fixed schedule of the 3x3 inverse
// ############################
`ifndef INV_CONSTS_SVH
`define INV_CONSTS_SVH

`define INV_N        3
`define INV_W        27
`define INV_FRAC     14
`define INV_DIV_LAT  `INV_W

// cholesky column window: products, sqrt load, divide
`define INV_STEP_CHOL 0
`define INV_CHOL_SQRT 4
`define INV_CHOL_DIV  (`INV_CHOL_SQRT + 1 + `INV_W / 2)
`define INV_CHOL_LEN  (`INV_CHOL_DIV + `INV_DIV_LAT + 1)

// triangular inverse window, one row of L^-1 each
`define INV_STEP_LTI  (`INV_STEP_CHOL + `INV_N * `INV_CHOL_LEN)
`define INV_LTI_DIV   3
`define INV_LTI_LEN   (`INV_LTI_DIV + `INV_DIV_LAT + 1)

`define INV_STEP_GRAM (`INV_STEP_LTI + `INV_N * `INV_LTI_LEN)
`define INV_STEP_LAST (`INV_STEP_GRAM + `INV_N + 1)

`endif

// ==== rtl/inv_pkg.sv ====
// ############################
// element, matrix and shared-array request types
// ############################
`include "inv_consts.svh"

package inv_pkg;

	// signed fixed point, INV_FRAC fraction bits
	typedef logic signed [`INV_W-1:0] elem_t;

	// [row][col]
	typedef elem_t [`INV_N-1:0][`INV_N-1:0] mat_t;

	// one element per lane of a shared array
	typedef elem_t [`INV_N-1:0] lanes_t;

	typedef struct packed {
		lanes_t dividends;
		elem_t  divisor;
	} div_req_t;

	typedef struct packed {
		lanes_t dataa;
		lanes_t datab;
	} mult_req_t;

	typedef logic [7:0] step_t;

endpackage

// ==== rtl/inv_sched.sv ====
// ############################
// step counter for the fixed inverse schedule
// ############################
`timescale 1ns/1ns
`include "inv_consts.svh"

module inv_sched (
	input  logic           i,
	input  logic           rst_n,
	input  logic           start,
	output logic           busy,
	output logic           run,
	output inv_pkg::step_t step,
	output logic           done
);
	import inv_pkg::*;

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			busy <= 1'b0;
			step <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (busy) begin
				if (step == step_t'(`INV_STEP_LAST)) begin
					busy <= 1'b0;
					done <= 1'b1;
					step <= '0;
				end else begin
					step <= step + 1'b1;
				end
			end else if (start) begin
				// start while busy falls through here unnoticed
				busy <= 1'b1;
				step <= '0;
			end
		end
	end

	assign run = busy;

endmodule

// ==== rtl/inverse.sv ====
// ############################
// 3x3 SPD inverse top, drive start with matrix held until done
// ############################
`timescale 1ns/1ns

module inverse (
	input  logic          i,
	input  logic          rst_n,
	input  logic          start,
	input  inv_pkg::mat_t matrix,
	output logic          busy,
	output logic          done,
	output inv_pkg::mat_t lt,
	output inv_pkg::mat_t lt_inverse,
	output inv_pkg::mat_t inv
);
	import inv_pkg::*;

	logic      run;
	step_t     step;
	div_req_t  chol_div_req;
	div_req_t  lti_div_req;
	div_req_t  div_req;
	mult_req_t chol_mult_req;
	mult_req_t lti_mult_req;
	mult_req_t mult_req;
	lanes_t    quotients;
	lanes_t    products;

	inv_sched u_sched (.i(i), .rst_n(rst_n), .start(start), .busy(busy), .run(run),
		.step(step), .done(done));

	cholesky u_chol (.i(i), .rst_n(rst_n), .run(run), .step(step), .matrix(matrix),
		.quotients(quotients), .products(products), .div_req(chol_div_req),
		.mult_req(chol_mult_req), .lt(lt));

	lt_inverse u_lti (.i(i), .rst_n(rst_n), .run(run), .step(step), .lt(lt),
		.quotients(quotients), .products(products), .div_req(lti_div_req),
		.mult_req(lti_mult_req), .lt_inverse(lt_inverse));

	// schedule keeps the two solvers' windows apart, idle side drives zeros
	assign div_req = chol_div_req | lti_div_req;
	assign mult_req = chol_mult_req | lti_mult_req;

	array_div u_div (.i(i), .rst_n(rst_n), .req(div_req), .quotients(quotients));

	array_mult u_mult (.i(i), .rst_n(rst_n), .req(mult_req), .products(products));

	gram_mult u_gram (.i(i), .rst_n(rst_n), .step(step), .lt_inverse(lt_inverse),
		.inv(inv));

endmodule

// ==== rtl/lt_inverse.sv ====
// ############################
// inverse of lower-triangular L, one row per window
// ############################
`timescale 1ns/1ns
`include "inv_consts.svh"

module lt_inverse (
	input  logic               i,
	input  logic               rst_n,
	input  logic               run,
	input  inv_pkg::step_t     step,
	input  inv_pkg::mat_t      lt,
	input  inv_pkg::lanes_t    quotients,
	input  inv_pkg::lanes_t    products,
	output inv_pkg::div_req_t  div_req,
	output inv_pkg::mult_req_t mult_req,
	output inv_pkg::mat_t      lt_inverse
);
	import inv_pkg::*;

	localparam int N = `INV_N;
	localparam elem_t ONE = elem_t'(1 << `INV_FRAC);

	logic       act;
	logic [1:0] row;
	step_t      offs;
	elem_t      sum [N];

	always_comb begin
		act = 1'b0;
		row = '0;
		offs = '0;
		for (int r = 0; r < N; r++) begin
			if (run && step >= step_t'(`INV_STEP_LTI + r * `INV_LTI_LEN) &&
				step < step_t'(`INV_STEP_LTI + (r + 1) * `INV_LTI_LEN)) begin
				act = 1'b1;
				row = 2'(r);
				offs = step - step_t'(`INV_STEP_LTI + r * `INV_LTI_LEN);
			end
		end
	end

	// row i of X: X[i][j] = -sum_k L[i][k] X[k][j] / L[i][i], X[i][i] = 1 / L[i][i]
	always_comb begin
		mult_req = '0;
		div_req = '0;
		if (act) begin
			for (int j = 0; j < N; j++) begin
				if (offs == step_t'(j) && j < row) begin
					for (int k = 0; k < N; k++) begin
						if (k >= j && k < row) begin
							mult_req.dataa[k] = lt[row][k];
							mult_req.datab[k] = lt_inverse[k][j];
						end
					end
				end
			end
			// divisor L[i][i] comes from the cholesky side
			if (offs == step_t'(`INV_LTI_DIV)) begin
				for (int j = 0; j < N; j++) begin
					if (j < row)
						div_req.dividends[j] = -sum[j];
					else if (j == row)
						div_req.dividends[j] = ONE;
				end
			end
		end
	end

	always_ff @(posedge i or negedge rst_n) begin
		if (!rst_n) begin
			lt_inverse <= '0;
			for (int j = 0; j < N; j++)
				sum[j] <= '0;
		end else if (act) begin
			for (int j = 0; j < N; j++)
				if (offs == step_t'(j + 1) && j < row)
					sum[j] <= products[0] + products[1] + products[2];
			if (offs == step_t'(`INV_LTI_DIV + `INV_DIV_LAT)) begin
				for (int j = 0; j < N; j++)
					if (j <= row)
						lt_inverse[row][j] <= quotients[j];
			end
		end
	end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_inverse
./obj_dir/Vtb_inverse > sim.log 2>&1
cat sim.log

if grep -q "Test failures found" sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"

// ==== tb/tb_clock.sv ====
// ##############################
// testbench clock, 20 ns period, and a reset held low for 10 cycles
// ##############################
`timescale 1ns/1ns

module tb_clock (
	output logic i,
	output logic rst_n
);

	initial begin
		i = 1'b0;
		forever #10 i = ~i;
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge i);
		rst_n <= 1'b1;
	end

endmodule

// ==== tb/tb_inverse.sv ====
// ##############################
// testbench for the 3x3 SPD inverse, fixed and random cases
// checked against a real-valued model
// ##############################
`timescale 1ns/1ns
`include "inv_consts.svh"

module tb_inverse;
	import inv_pkg::*;

	localparam int N = `INV_N;
	localparam real SCALE = 1.0 * (1 << `INV_FRAC);
	localparam int RUN_LIMIT = `INV_STEP_LAST + 20;

	logic i;
	logic rst_n;
	logic start;
	mat_t matrix;
	logic busy;
	logic done;
	mat_t lt;
	mat_t lt_inverse;
	mat_t inv;

	logic [31:0] seed;
	int checks;
	int errors;
	int timeouts;
	real a_ref [N][N];
	real inv_ref [N][N];

	tb_clock u_clock (.i(i), .rst_n(rst_n));

	inverse uut (.i(i), .rst_n(rst_n), .start(start), .matrix(matrix), .busy(busy),
		.done(done), .lt(lt), .lt_inverse(lt_inverse), .inv(inv));

	function automatic logic [31:0] lcg_next();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic real to_real(input elem_t e);
		int v;
		v = e;
		return real'(v) / SCALE;
	endfunction

	function automatic elem_t to_elem(input real x);
		return elem_t'($rtoi(x * SCALE + ((x < 0.0) ? -0.5 : 0.5)));
	endfunction

	// 2^-8 relative, with a floor of one for entries near zero
	function automatic real tol(input real e);
		real m;
		m = (e < 0.0) ? -e : e;
		if (m < 1.0)
			m = 1.0;
		return m / 256.0;
	endfunction

	task automatic check_close(input string name, input real exp, input real act);
		checks++;
		assert ((act - exp <= tol(exp)) && (exp - act <= tol(exp))) else begin
			errors++;
			$display("** Error at %0t ns: %s expected %f, got %f", $time, name, exp, act);
		end
	endtask

	task automatic check_exact(input string name, input int exp, input int act);
		checks++;
		assert (act == exp) else begin
			errors++;
			$display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
		end
	endtask

	// B*B^T + 3I, entries of B in steps of 1/8 so A is exact
	task automatic make_random();
		real b [N][N];
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				b[r][c] = real'(int'(lcg_next() >> 16) % 17 - 8) / 8.0;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				a_ref[r][c] = (r == c) ? 3.0 : 0.0;
				for (int k = 0; k < N; k++)
					a_ref[r][c] += b[r][k] * b[c][k];
			end
		end
	endtask

	task automatic make_diagonal(input real d0, input real d1, input real d2);
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				a_ref[r][c] = 0.0;
		a_ref[0][0] = d0;
		a_ref[1][1] = d1;
		a_ref[2][2] = d2;
	endtask

	// cyclic cofactors give the signed 3x3 adjugate directly
	task automatic reference_inverse();
		real cof [N][N];
		real det;
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				cof[r][c] = a_ref[(r+1)%N][(c+1)%N] * a_ref[(r+2)%N][(c+2)%N] -
					a_ref[(r+1)%N][(c+2)%N] * a_ref[(r+2)%N][(c+1)%N];
		det = a_ref[0][0] * cof[0][0] + a_ref[0][1] * cof[0][1] + a_ref[0][2] * cof[0][2];
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				inv_ref[r][c] = cof[c][r] / det;
	endtask

	task automatic check_results(input string tag);
		real lv [N][N];
		real xv [N][N];
		real s;
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				lv[r][c] = to_real(lt[r][c]);
				xv[r][c] = to_real(lt_inverse[r][c]);
				if (c > r) begin
					check_exact($sformatf("%s lt[%0d][%0d]", tag, r, c), 0, int'(lt[r][c]));
					check_exact($sformatf("%s lt_inverse[%0d][%0d]", tag, r, c), 0,
						int'(lt_inverse[r][c]));
				end
			end
		end
		for (int r = 0; r < N; r++) begin
			checks++;
			assert (lv[r][r] > 0.0) else begin
				errors++;
				$display("%s: diagonal entry %0d of lt is not positive (%f)", tag, r, lv[r][r]);
			end
		end
		for (int r = 0; r < N; r++) begin
			for (int c = 0; c < N; c++) begin
				s = 0.0;
				for (int k = 0; k < N; k++)
					s += lv[r][k] * lv[c][k];
				check_close($sformatf("%s lt*lt^T[%0d][%0d]", tag, r, c), a_ref[r][c], s);
				s = 0.0;
				for (int k = 0; k < N; k++)
					s += xv[r][k] * lv[k][c];
				check_close($sformatf("%s lt_inverse*lt[%0d][%0d]", tag, r, c),
					(r == c) ? 1.0 : 0.0, s);
				check_close($sformatf("%s inv[%0d][%0d]", tag, r, c), inv_ref[r][c],
					to_real(inv[r][c]));
			end
		end
	endtask

	// stray_at > 0 puts a second start pulse into the running computation
	task automatic run_case(input string tag, input int stray_at);
		mat_t m;
		int n;
		bit seen;
		reference_inverse();
		for (int r = 0; r < N; r++)
			for (int c = 0; c < N; c++)
				m[r][c] = to_elem(a_ref[r][c]);
		@(posedge i);
		matrix <= m;
		start <= 1'b1;
		@(posedge i);
		start <= 1'b0;
		n = 1;
		seen = 1'b0;
		while (!seen && n <= RUN_LIMIT) begin
			@(negedge i);
			if (done) begin
				seen = 1'b1;
				check_exact($sformatf("%s done cycle", tag), `INV_STEP_LAST + 2, n);
				check_exact($sformatf("%s busy", tag), 0, int'(busy));
			end else begin
				check_exact($sformatf("%s busy", tag), 1, int'(busy));
				@(posedge i);
				start <= (n == stray_at);
				n++;
			end
		end
		if (!seen) begin
			timeouts++;
			$display("timeout: done never came for case %s", tag);
		end else begin
			check_results(tag);
			@(negedge i);
			check_exact($sformatf("%s done width", tag), 0, int'(done));
		end
	endtask

	initial begin
		int n;
		start = 1'b0;
		matrix = '0;
		seed = 32'he2ed;
		checks = 0;
		errors = 0;
		timeouts = 0;
		n = 0;
		while (!rst_n && n < 50) begin
			@(posedge i);
			n++;
		end
		if (!rst_n) begin
			timeouts++;
			$display("timeout: reset was never released");
		end else begin
			// idle after reset
			for (int k = 0; k < 5; k++) begin
				@(negedge i);
				check_exact("busy after reset", 0, int'(busy));
				check_exact("done after reset", 0, int'(done));
			end
			make_diagonal(1.0, 1.0, 1.0);
			run_case("identity", 0);
			if (timeouts == 0) begin
				make_diagonal(2.25, 4.0, 0.5625);
				run_case("diagonal", 100);
			end
			for (int t = 0; t < 20; t++) begin
				if (timeouts == 0) begin
					make_random();
					run_case($sformatf("random %0d", t), (t % 3 == 0) ? 50 + 8 * t : 0);
				end
			end
		end
		$display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule
